// File: logic/sprite_pkg.sv
package sprite_pkg;

  // horizontal timing in clocks
  localparam int H_DISPLAY = 256;
  localparam int H_FRONT   = 7;
  localparam int H_SYNC    = 23;
  localparam int H_BACK    = 23;
  localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

  // vertical timing in lines
  localparam int V_DISPLAY = 240;
  localparam int V_BOTTOM  = 14;
  localparam int V_SYNC    = 3;
  localparam int V_TOP     = 5;
  localparam int V_TOTAL   = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP;

  localparam int POS_W = 9;

  // sprite table and per-line slot array
  localparam int NUM_SPRITES  = 32;
  localparam int SPRITE_IDX_W = 5;
  localparam int LINE_SPRITES = 4;
  localparam int LINE_IDX_W   = 2;
  localparam int SPRITE_SIZE  = 16;
  localparam int COLOR_W      = 4;
  localparam int ROM_ADDR_W   = 8;

  // below the visible area, so a reset sprite never lands on screen
  localparam int RESET_YPOS = 240;

  // renderer phases, all counted in hpos
  localparam int SELECT_END = 2 * NUM_SPRITES;
  localparam int COPY_END   = SELECT_END + 4 * LINE_SPRITES;
  localparam int DRAW_END   = COPY_END + 2 * SPRITE_SIZE * LINE_SPRITES;

endpackage

// File: logic/video_timing.sv
`timescale 1ns/1ps

module video_timing import sprite_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  output logic             hsync,
  output logic             vsync,
  output logic             display_on,
  output logic [POS_W-1:0] hpos,
  output logic [POS_W-1:0] vpos
);

  logic h_last;
  logic v_last;

  assign h_last = (hpos == POS_W'(H_TOTAL - 1));
  assign v_last = (vpos == POS_W'(V_TOTAL - 1));

  // raster counters, vpos steps once per line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (h_last) begin
      hpos <= '0;
      if (v_last) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 1'b1;
      end
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // sync pulses sit between the front and back porch
  assign hsync = (hpos >= POS_W'(H_DISPLAY + H_FRONT)) &&
                 (hpos <  POS_W'(H_DISPLAY + H_FRONT + H_SYNC));
  assign vsync = (vpos >= POS_W'(V_DISPLAY + V_BOTTOM)) &&
                 (vpos <  POS_W'(V_DISPLAY + V_BOTTOM + V_SYNC));

  assign display_on = (hpos < POS_W'(H_DISPLAY)) && (vpos < POS_W'(V_DISPLAY));

  a_pos_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (hpos < POS_W'(H_TOTAL)) && (vpos < POS_W'(V_TOTAL))
  );

endmodule

// File: logic/sprite_bitmap_rom.sv
`timescale 1ns/1ps

module sprite_bitmap_rom import sprite_pkg::*; (
  input  logic [ROM_ADDR_W-1:0]  rom_addr,
  output logic [SPRITE_SIZE-1:0] rom_data
);

  logic [3:0] shape;
  logic [3:0] row;

  // upper nibble picks the shape, lower nibble the row
  assign shape = rom_addr[ROM_ADDR_W-1:ROM_ADDR_W-4];
  assign row   = rom_addr[3:0];

  always_comb begin
    rom_data = '0;
    case (shape)
      // little ghost
      4'd0: begin
        case (row)
          4'd0:    rom_data = 16'b0000011111100000;
          4'd1:    rom_data = 16'b0001111111111000;
          4'd2:    rom_data = 16'b0011111111111100;
          4'd3:    rom_data = 16'b0111001111001110;
          4'd4:    rom_data = 16'b0110000110000110;
          4'd5:    rom_data = 16'b0110110110110110;
          4'd6:    rom_data = 16'b1111001111001111;
          4'd13:   rom_data = 16'b1110111001110111;
          4'd14:   rom_data = 16'b1100011001100011;
          4'd15:   rom_data = 16'b1000001001000001;
          default: rom_data = 16'b1111111111111111;
        endcase
      end
      4'd1: rom_data = '1;
      4'd2: rom_data = row[0] ? 16'hAAAA : 16'h5555;
      // hollow frame
      4'd3: begin
        if (row == 4'd0 || row == 4'd15) begin
          rom_data = '1;
        end else begin
          rom_data = 16'h8001;
        end
      end
      default: rom_data = '0;
    endcase
  end

endmodule

// File: logic/sprite_table.sv
`timescale 1ns/1ps

module sprite_table import sprite_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  logic [SPRITE_IDX_W-1:0] wr_index,
  input  logic [7:0]              wr_xpos,
  input  logic [7:0]              wr_ypos,
  input  logic [7:0]              wr_attr,
  input  logic [SPRITE_IDX_W-1:0] rd_index,
  output logic [7:0]              rd_xpos,
  output logic [7:0]              rd_ypos,
  output logic [7:0]              rd_attr
);

  logic [7:0] sprite_xpos [NUM_SPRITES];
  logic [7:0] sprite_ypos [NUM_SPRITES];
  // attr[7:4] shape, attr[3:0] colour
  logic [7:0] sprite_attr [NUM_SPRITES];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // park every sprite below the visible area
      for (int n = 0; n < NUM_SPRITES; n++) begin
        sprite_xpos[n] <= '0;
        sprite_ypos[n] <= 8'(RESET_YPOS);
        sprite_attr[n] <= '0;
      end
    end else if (wr_en) begin
      sprite_xpos[wr_index] <= wr_xpos;
      sprite_ypos[wr_index] <= wr_ypos;
      sprite_attr[wr_index] <= wr_attr;
    end
  end

  // renderer reads without latency
  assign rd_xpos = sprite_xpos[rd_index];
  assign rd_ypos = sprite_ypos[rd_index];
  assign rd_attr = sprite_attr[rd_index];

  a_wr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown({wr_index, wr_attr})
  );

endmodule

// File: logic/sprite_scanline_renderer.sv
`timescale 1ns/1ps

module sprite_scanline_renderer import sprite_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [POS_W-1:0]        hpos,
  input  logic [POS_W-1:0]        vpos,
  output logic [SPRITE_IDX_W-1:0] rd_index,
  input  logic [7:0]              rd_xpos,
  input  logic [7:0]              rd_ypos,
  input  logic [7:0]              rd_attr,
  output logic [ROM_ADDR_W-1:0]   rom_addr,
  input  logic [SPRITE_SIZE-1:0]  rom_data,
  output logic                    wr_pix_en,
  output logic [7:0]              wr_col,
  output logic [COLOR_W-1:0]      wr_color
);

  // line slot array, filled in table order
  logic [SPRITE_IDX_W-1:0] slot_index [LINE_SPRITES];
  logic [3:0]              slot_yofs  [LINE_SPRITES];
  logic [7:0]              slot_xpos  [LINE_SPRITES];
  logic [7:0]              slot_attr  [LINE_SPRITES];
  logic [LINE_SPRITES-1:0] slot_active;

  // one extra bit so the count saturates at four instead of wrapping
  logic [LINE_IDX_W:0]     sel_count;
  logic [LINE_IDX_W-1:0]   sel_slot;
  logic [7:0]              yofs;
  logic                    sel_hit;

  logic [SPRITE_SIZE-1:0]  out_bitmap;
  logic [COLOR_W-1:0]      out_color;
  logic [7:0]              write_ofs;

  logic                    render_on;
  logic                    sel_phase;
  logic                    copy_phase;
  logic                    draw_phase;
  logic [LINE_IDX_W-1:0]   copy_slot;
  logic [POS_W-1:0]        draw_ofs;
  logic [LINE_IDX_W-1:0]   draw_slot;
  logic [4:0]              draw_step;

  // nothing is prepared on lines 256 and up
  assign render_on  = !vpos[POS_W-1];
  assign sel_phase  = render_on && (hpos < POS_W'(SELECT_END));
  assign copy_phase = render_on && (hpos >= POS_W'(SELECT_END)) &&
                      (hpos < POS_W'(COPY_END));
  assign draw_phase = render_on && (hpos >= POS_W'(COPY_END)) &&
                      (hpos < POS_W'(DRAW_END));

  // four clocks per slot during copy, 32 per slot during draw
  assign copy_slot = hpos[LINE_IDX_W+1:2];
  assign draw_ofs  = hpos - POS_W'(COPY_END);
  assign draw_slot = draw_ofs[LINE_IDX_W+4:5];
  assign draw_step = draw_ofs[4:0];

  assign sel_slot = sel_count[LINE_IDX_W-1:0];
  assign sel_hit  = sel_phase && hpos[0] && (yofs < 8'(SPRITE_SIZE)) &&
                    !sel_count[LINE_IDX_W];

  // even clocks scan entry hpos/2, copy walks the chosen indices
  assign rd_index = sel_phase ? hpos[SPRITE_IDX_W:1] : slot_index[copy_slot];

  assign rom_addr = {slot_attr[draw_slot][7:4], slot_yofs[draw_slot]};

  // second half of each 32-clock slot emits one pixel per clock
  assign wr_pix_en = draw_phase && draw_step[4] && out_bitmap[0];
  assign wr_col    = write_ofs;
  assign wr_color  = out_color;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_count   <= '0;
      slot_active <= '0;
    end else if (!render_on) begin
      sel_count <= '0;
    end else begin
      if (sel_hit) begin
        slot_active[sel_slot] <= 1'b1;
        sel_count             <= sel_count + 1'b1;
      end
      if (draw_phase) begin
        sel_count <= '0;
        // slot is consumed once its row has been fetched
        if (draw_step == 5'd3) begin
          slot_active[draw_slot] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_phase && !hpos[0]) begin
      yofs <= vpos[7:0] - rd_ypos;
    end
    if (sel_hit) begin
      slot_index[sel_slot] <= hpos[SPRITE_IDX_W:1];
      slot_yofs[sel_slot]  <= yofs[3:0];
    end

    if (copy_phase) begin
      case (hpos[1:0])
        2'd0:    slot_xpos[copy_slot] <= rd_xpos;
        2'd1:    slot_attr[copy_slot] <= rd_attr;
        default: ;
      endcase
    end

    if (draw_phase) begin
      if (!draw_step[4]) begin
        case (draw_step[3:0])
          4'd0:    write_ofs  <= slot_xpos[draw_slot];
          // an empty slot fetches a blank row
          4'd1:    out_bitmap <= slot_active[draw_slot] ? rom_data : '0;
          4'd2:    out_color  <= slot_attr[draw_slot][COLOR_W-1:0];
          default: ;
        endcase
      end else begin
        // lsb first, column wraps inside the 256-wide half
        out_bitmap <= out_bitmap >> 1;
        write_ofs  <= write_ofs + 1'b1;
      end
    end
  end

  a_pix_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_pix_en |-> (hpos >= POS_W'(COPY_END + SPRITE_SIZE)) &&
                  (hpos < POS_W'(DRAW_END)) &&
                  (((hpos - POS_W'(COPY_END)) % (2 * SPRITE_SIZE)) >= SPRITE_SIZE)
  );

endmodule

// File: logic/scanline_buffer.sv
`timescale 1ns/1ps

module scanline_buffer import sprite_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [POS_W-1:0]   hpos,
  input  logic [POS_W-1:0]   vpos,
  input  logic               wr_pix_en,
  input  logic [7:0]         wr_col,
  input  logic [COLOR_W-1:0] wr_color,
  output logic [COLOR_W-1:0] rgb
);

  logic [COLOR_W-1:0] line_mem [2 * H_DISPLAY];
  logic [8:0]         rd_addr;
  logic [8:0]         wr_addr;
  logic               read_on;

  // display reads half vpos[0], renderer fills the other one
  assign rd_addr = {vpos[0], hpos[7:0]};
  assign wr_addr = {~vpos[0], wr_col};
  assign read_on = (hpos < POS_W'(H_DISPLAY));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < 2 * H_DISPLAY; n++) begin
        line_mem[n] <= '0;
      end
    end else begin
      // each entry is wiped as it goes out
      if (read_on) begin
        line_mem[rd_addr] <= '0;
      end
      if (wr_pix_en) begin
        line_mem[wr_addr] <= wr_color;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rgb <= '0;
    end else begin
      rgb <= (read_on && vpos < POS_W'(V_DISPLAY)) ? line_mem[rd_addr] : '0;
    end
  end

  a_write_other_half: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_pix_en |-> (wr_addr[8] != rd_addr[8]) && !vpos[POS_W-1]
  );

endmodule

// File: logic/sprite_video_top.sv
`timescale 1ns/1ps

module sprite_video_top import sprite_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  logic [SPRITE_IDX_W-1:0] wr_index,
  input  logic [7:0]              wr_xpos,
  input  logic [7:0]              wr_ypos,
  input  logic [7:0]              wr_attr,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    display_on,
  output logic [POS_W-1:0]        hpos,
  output logic [POS_W-1:0]        vpos,
  output logic [COLOR_W-1:0]      rgb
);

  logic [SPRITE_IDX_W-1:0] rd_index;
  logic [7:0]              rd_xpos;
  logic [7:0]              rd_ypos;
  logic [7:0]              rd_attr;
  logic [ROM_ADDR_W-1:0]   rom_addr;
  logic [SPRITE_SIZE-1:0]  rom_data;
  logic                    wr_pix_en;
  logic [7:0]              wr_col;
  logic [COLOR_W-1:0]      wr_color;

  video_timing u_timing (
    .clk(clk), .rst_n(rst_n), .hsync(hsync), .vsync(vsync),
    .display_on(display_on), .hpos(hpos), .vpos(vpos)
  );

  sprite_table u_table (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_index(wr_index),
    .wr_xpos(wr_xpos), .wr_ypos(wr_ypos), .wr_attr(wr_attr),
    .rd_index(rd_index), .rd_xpos(rd_xpos), .rd_ypos(rd_ypos), .rd_attr(rd_attr)
  );

  sprite_bitmap_rom u_rom (
    .rom_addr(rom_addr), .rom_data(rom_data)
  );

  sprite_scanline_renderer u_renderer (
    .clk(clk), .rst_n(rst_n), .hpos(hpos), .vpos(vpos),
    .rd_index(rd_index), .rd_xpos(rd_xpos), .rd_ypos(rd_ypos), .rd_attr(rd_attr),
    .rom_addr(rom_addr), .rom_data(rom_data),
    .wr_pix_en(wr_pix_en), .wr_col(wr_col), .wr_color(wr_color)
  );

  scanline_buffer u_buffer (
    .clk(clk), .rst_n(rst_n), .hpos(hpos), .vpos(vpos),
    .wr_pix_en(wr_pix_en), .wr_col(wr_col), .wr_color(wr_color), .rgb(rgb)
  );

endmodule

// File: tb/sprite_video_tb.sv
`timescale 1ns/1ps

module sprite_video_tb import sprite_pkg::*; ();

  localparam int NUM_TESTS  = 10;
  localparam int MAX_WRITES = 6;
  localparam int CLK_NS     = 40;
  localparam longint FRAME_NS = longint'(H_TOTAL) * V_TOTAL * CLK_NS;
  // one frame per table row, two spare frames, plus a hundred lines of slack
  localparam longint WATCHDOG_NS = (NUM_TESTS + 2) * FRAME_NS + 100 * H_TOTAL * CLK_NS;

  logic                    clk;
  logic                    rst_n;
  logic                    wr_en;
  logic [SPRITE_IDX_W-1:0] wr_index;
  logic [7:0]              wr_xpos;
  logic [7:0]              wr_ypos;
  logic [7:0]              wr_attr;
  logic                    hsync;
  logic                    vsync;
  logic                    display_on;
  logic [POS_W-1:0]        hpos;
  logic [POS_W-1:0]        vpos;
  logic [COLOR_W-1:0]      rgb;

  sprite_video_top u_dut (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_index(wr_index),
    .wr_xpos(wr_xpos), .wr_ypos(wr_ypos), .wr_attr(wr_attr),
    .hsync(hsync), .vsync(vsync), .display_on(display_on),
    .hpos(hpos), .vpos(vpos), .rgb(rgb)
  );

  // stimulus table, each write packed as {index, x, y, attr}
  string       test_name  [NUM_TESTS];
  logic [31:0] test_wr    [NUM_TESTS][MAX_WRITES];
  int          test_nwr   [NUM_TESTS];
  bit          test_clear [NUM_TESTS];
  int          test_lines [NUM_TESTS];

  // reference sprite table and the picture it should produce
  logic [7:0]         ref_x    [NUM_SPRITES];
  logic [7:0]         ref_y    [NUM_SPRITES];
  logic [7:0]         ref_attr [NUM_SPRITES];
  logic [COLOR_W-1:0] exp_pix  [V_DISPLAY][H_DISPLAY];
  int                 prev_idx [$];
  logic [31:0]        rng_state;
  string              cur_test;

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] s;
    s = rng_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state = s;
    return s;
  endfunction

  function automatic logic [31:0] sprite_word(input int idx, input int x, input int y,
                                              input int attr);
    return {8'(idx), 8'(x), 8'(y), 8'(attr)};
  endfunction

  // bitmap rows as the shape table defines them, bit 0 is the leftmost pixel
  function automatic logic [15:0] shape_row(input logic [3:0] shape, input logic [3:0] row);
    case (shape)
      4'd1:    return 16'hFFFF;
      4'd2:    return row[0] ? 16'hAAAA : 16'h5555;
      4'd3:    return (row == 4'd0 || row == 4'd15) ? 16'hFFFF : 16'h8001;
      default: return 16'h0000;
    endcase
  endfunction

  function automatic logic [COLOR_W-1:0] expected_pixel(input int h, input int v);
    if (h < H_DISPLAY && v < V_DISPLAY) begin
      return exp_pix[v][h];
    end
    return '0;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string what, input int row, input int col,
                          input logic [31:0] exp_val, input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      report_failure($sformatf("[FAIL] %s %s row %0d col %0d expected %0h actual %0h",
                               cur_test, what, row, col, exp_val, act_val));
    end
  endtask

  task automatic fill_table();
    logic [31:0] r;
    test_name[0] = "reset_frame";   test_nwr[0] = 0; test_clear[0] = 0;
    test_name[1] = "solid_block";   test_nwr[1] = 1; test_clear[1] = 0;
    test_wr[1][0] = sprite_word(1, 40, 30, 8'h15);
    test_name[2] = "wrap_frame";    test_nwr[2] = 1; test_clear[2] = 1;
    test_wr[2][0] = sprite_word(2, 248, 100, 8'h37);
    test_name[3] = "overlap";       test_nwr[3] = 2; test_clear[3] = 1;
    test_wr[3][0] = sprite_word(3, 60, 50, 8'h19);
    test_wr[3][1] = sprite_word(4, 66, 54, 8'h2C);
    test_name[4] = "six_same_rows"; test_nwr[4] = 6; test_clear[4] = 1;
    for (int k = 0; k < 6; k++) begin
      test_wr[4][k] = sprite_word(5 + k, 10 + 30 * k, 120, 8'h10 + k + 1);
    end
    // random rows, shapes 1 to 3 and nonzero colours
    for (int t = 5; t < NUM_TESTS; t++) begin
      test_name[t]  = $sformatf("random_%0d", t - 5);
      test_nwr[t]   = MAX_WRITES;
      test_clear[t] = 1;
      for (int k = 0; k < MAX_WRITES; k++) begin
        r = xorshift();
        test_wr[t][k] = sprite_word(r % NUM_SPRITES, xorshift() % 256, xorshift() % 224,
                                    ((1 + xorshift() % 3) << 4) | (1 + xorshift() % 15));
      end
    end
    // the reset row checks a whole frame, the others only the visible lines
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_lines[t] = (test_nwr[t] == 0) ? V_TOTAL : V_DISPLAY;
    end
  endtask

  task automatic set_sprite(input logic [7:0] idx, input logic [7:0] x, input logic [7:0] y,
                            input logic [7:0] attr);
    wr_en    = 1'b1;
    wr_index = idx[SPRITE_IDX_W-1:0];
    wr_xpos  = x;
    wr_ypos  = y;
    wr_attr  = attr;
    @(negedge clk);
    ref_x[idx[SPRITE_IDX_W-1:0]]    = x;
    ref_y[idx[SPRITE_IDX_W-1:0]]    = y;
    ref_attr[idx[SPRITE_IDX_W-1:0]] = attr;
  endtask

  // row r shows the first four sprites, in index order, that cover line r-1
  task automatic build_model();
    int          cnt;
    logic [7:0]  src_line;
    logic [7:0]  yofs;
    logic [7:0]  col;
    logic [15:0] bits;
    for (int r = 0; r < V_DISPLAY; r++) begin
      for (int c = 0; c < H_DISPLAY; c++) begin
        exp_pix[r][c] = '0;
      end
      if (r > 0) begin
        src_line = 8'(r - 1);
        cnt      = 0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
          yofs = src_line - ref_y[s];
          if (cnt < LINE_SPRITES && yofs < 8'(SPRITE_SIZE)) begin
            cnt++;
            bits = shape_row(ref_attr[s][7:4], yofs[3:0]);
            for (int k = 0; k < SPRITE_SIZE; k++) begin
              col = ref_x[s] + 8'(k);
              if (bits[k]) begin
                exp_pix[r][col] = ref_attr[s][COLOR_W-1:0];
              end
            end
          end
        end
      end
    end
  endtask

  // starts at the negedge where hpos and vpos are both 0
  task automatic check_frame(input int n_lines);
    int   n_samples;
    int   exp_h;
    int   exp_v;
    int   prev_h;
    int   prev_v;
    int   hs_pulses;
    int   vs_pulses;
    logic prev_hs;
    logic prev_vs;
    n_samples = H_TOTAL * n_lines + 1;
    exp_h     = 0;
    exp_v     = 0;
    prev_h    = 0;
    prev_v    = 0;
    hs_pulses = 0;
    vs_pulses = 0;
    prev_hs   = 1'b0;
    prev_vs   = 1'b0;
    for (int i = 0; i < n_samples; i++) begin
      check_eq("hpos", exp_v, exp_h, exp_h, hpos);
      check_eq("vpos", exp_v, exp_h, exp_v, vpos);
      // hsync covers columns 263 to 285, vsync covers lines 254 to 256
      check_eq("hsync", exp_v, exp_h, (exp_h >= 263) && (exp_h <= 285), hsync);
      check_eq("vsync", exp_v, exp_h, (exp_v >= 254) && (exp_v <= 256), vsync);
      check_eq("display_on", exp_v, exp_h, (exp_h < H_DISPLAY) && (exp_v < V_DISPLAY),
               display_on);
      // rgb lags the raster position by one clock
      if (i > 0) begin
        check_eq("rgb", prev_v, prev_h, expected_pixel(prev_h, prev_v), rgb);
      end
      if (hsync && !prev_hs) hs_pulses++;
      if (vsync && !prev_vs) vs_pulses++;
      prev_hs = hsync;
      prev_vs = vsync;
      prev_h  = exp_h;
      prev_v  = exp_v;
      exp_h++;
      if (exp_h == H_TOTAL) begin
        exp_h = 0;
        exp_v = (exp_v + 1) % V_TOTAL;
      end
      if (i < n_samples - 1) begin
        @(negedge clk);
      end
    end
    check_eq("hsync pulses", exp_v, exp_h, n_lines, hs_pulses);
    check_eq("vsync pulses", exp_v, exp_h, (n_lines > V_DISPLAY + V_BOTTOM) ? 1 : 0,
             vs_pulses);
  endtask

  initial begin
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    wr_index  = '0;
    wr_xpos   = '0;
    wr_ypos   = '0;
    wr_attr   = '0;
    rng_state = 32'd8989;
    cur_test  = "reset";
    for (int n = 0; n < NUM_SPRITES; n++) begin
      ref_x[n]    = '0;
      ref_y[n]    = 8'(RESET_YPOS);
      ref_attr[n] = '0;
    end
    fill_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test = test_name[t];
      if (test_nwr[t] > 0 || test_clear[t]) begin
        // host writes only below the visible area
        while (vpos < POS_W'(V_DISPLAY)) @(negedge clk);
        if (test_clear[t]) begin
          foreach (prev_idx[p]) begin
            set_sprite(8'(prev_idx[p]), 8'd0, 8'(RESET_YPOS), 8'd0);
          end
        end
        prev_idx.delete();
        for (int w = 0; w < test_nwr[t]; w++) begin
          set_sprite(test_wr[t][w][31:24], test_wr[t][w][23:16], test_wr[t][w][15:8],
                     test_wr[t][w][7:0]);
          prev_idx.push_back(test_wr[t][w][31:24]);
        end
        wr_en = 1'b0;
      end
      build_model();
      while (!(hpos == '0 && vpos == '0)) @(negedge clk);
      check_frame(test_lines[t]);
    end
    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout: the watchdog expired before the test table finished");
  end

endmodule

// File: all.f
logic/sprite_pkg.sv
logic/video_timing.sv
logic/sprite_bitmap_rom.sv
logic/sprite_table.sv
logic/sprite_scanline_renderer.sv
logic/scanline_buffer.sv
logic/sprite_video_top.sv
tb/sprite_video_tb.sv
